/* Makefile */
TOP := core_ma_lsu_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* build.f */
+incdir+verilog
verilog/core_lsu_pkg.sv
verilog/fifo_sync_bypass.sv
verilog/core_ma_lsu_generate_addr.sv
verilog/core_ma_lsu_generate_data.sv
verilog/core_ma_lsu.sv
verilog/avl_sram_slave.sv
verilog/core_ma_lsu_top.sv
verification/core_ma_lsu_assertions.sv
verification/core_ma_lsu_tb.sv

/* verification/core_ma_lsu_assertions.sv */
`timescale 1ns/1ps

`include "core_lsu_params.svh"

module core_ma_lsu_assertions
  import core_lsu_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input mem_cmd_t cmd,
  input logic     fifo_write,
  input logic     head_pop,
  input avl_req_t avl_req,
  input avl_rsp_t avl_rsp
);

  logic       req_waiting;
  logic [3:0] cmd_count;   // Commands waiting, counted from writes and pops

  assign req_waiting = (avl_req.read || avl_req.write) && !avl_rsp.request_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_count <= '0;
    end else begin
      cmd_count <= cmd_count + 4'(fifo_write) - 4'(head_pop);
    end
  end

  req_stable_a: assert property (@(posedge clk) disable iff (rst)
    req_waiting |=> $stable(avl_req))
    else $error("Bus request changed before the slave accepted it");

  half_aligned_a: assert property (@(posedge clk) disable iff (rst)
    fifo_write && (cmd.op == MEM_OP_H || cmd.op == MEM_OP_HU) |-> !cmd.addr[0])
    else $error("Misaligned halfword access at %08h", cmd.addr);

  word_aligned_a: assert property (@(posedge clk) disable iff (rst)
    fifo_write && cmd.op == MEM_OP_W |-> cmd.addr[1:0] == 2'b00)
    else $error("Misaligned word access at %08h", cmd.addr);

  one_strobe_a: assert property (@(posedge clk) disable iff (rst)
    !(cmd.read && cmd.write) && !(avl_req.read && avl_req.write))
    else $error("Read and write high together");

  no_full_write_a: assert property (@(posedge clk) disable iff (rst)
    fifo_write |-> cmd_count < 4'(`CMD_FIFO_DEPTH))
    else $error("Command FIFO written while full");

endmodule

bind core_ma_lsu core_ma_lsu_assertions i_core_ma_lsu_assertions (
  .clk        (clk),
  .rst        (rst),
  .cmd        (cmd),
  .fifo_write (fifo_write),
  .head_pop   (head_pop),
  .avl_req    (avl_req),
  .avl_rsp    (avl_rsp)
);

/* verification/core_ma_lsu_stim.txt */
# name  op(R/W)  width(B H W BU HU)  addr  store_data  expected_load, all hex
# Names starting with bp_ run with random bus stall
wr_w0  W W  00000000 11223344 00000000
wr_w1  W W  00000004 a5a55a5a 00000000
rd_w0  R W  00000000 00000000 11223344
rd_w1  R W  00000004 00000000 a5a55a5a
wr_b0  W B  00000010 12345681 00000000
wr_b1  W B  00000011 000000f2 00000000
wr_b2  W B  00000012 ffffff63 00000000
wr_b3  W B  00000013 000000c4 00000000
rd_m0  R W  00000010 00000000 c463f281
rd_b0  R B  00000010 00000000 ffffff81
rd_bu0 R BU 00000010 00000000 00000081
rd_b1  R B  00000011 00000000 fffffff2
wr_m1  W W  00000014 12345678 00000000
rd_b2  R B  00000012 00000000 00000063
rd_bu3 R BU 00000013 00000000 000000c4
wr_h2  W H  00000016 0000beef 00000000
rd_m1  R W  00000014 00000000 beef5678
wr_h0  W H  00000014 ffff8001 00000000
rd_m2  R W  00000014 00000000 beef8001
rd_h0  R H  00000014 00000000 ffff8001
rd_hu2 R HU 00000016 00000000 0000beef
rd_h2  R H  00000016 00000000 ffffbeef
bp_w0  W W  00000100 0badf00d 00000000
bp_w1  W W  00000104 cafe1234 00000000
bp_b5  W B  00000105 0000007e 00000000
bp_h2  W H  0000010a 00009abc 00000000
bp_r0  R W  00000100 00000000 0badf00d
bp_r1  R W  00000104 00000000 cafe7e34
bp_r2  R HU 0000010a 00000000 00009abc
bp_r3  R H  0000010a 00000000 ffff9abc
bp_w2  W W  000003fc 80000000 00000000
bp_r4  R B  000003ff 00000000 ffffff80
bp_r5  R BU 000003ff 00000000 00000080
bp_r6  R H  00000102 00000000 00000bad

/* verification/core_ma_lsu_tb.sv */
`timescale 1ns/1ps

module core_ma_lsu_tb
  import core_lsu_pkg::*;
();

  logic        clk;
  logic        rst;
  mem_cmd_t    cmd;
  logic        lsu_ready;
  logic        bus_stall;
  logic [31:0] mem_read_data;
  logic        mem_read_data_valid;

  string       name_q[$];
  logic        is_read_q[$];
  mem_op_e     op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  string       pend_name[$];   // Loads in flight, oldest first
  logic [31:0] pend_exp[$];

  integer      seed;
  logic        stall_en;
  logic        stim_ready = 1'b0;

  core_ma_lsu_top i_core_ma_lsu_top (
    .clk                 (clk),
    .rst                 (rst),
    .cmd                 (cmd),
    .lsu_ready           (lsu_ready),
    .bus_stall           (bus_stall),
    .mem_read_data       (mem_read_data),
    .mem_read_data_valid (mem_read_data_valid)
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic read_stim_file();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       dir;
    string       width;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    mem_op_e     op;
    fd = $fopen("verification/core_ma_lsu_stim.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Cannot open the stimulus file");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %s %h %h %h", name, dir, width, addr, data, expected);
        if (n != 6 || (dir != "R" && dir != "W")) begin
          stop_with_failure({"Malformed stimulus line: ", line});
        end
        case (width)
          "B":     op = MEM_OP_B;
          "H":     op = MEM_OP_H;
          "W":     op = MEM_OP_W;
          "BU":    op = MEM_OP_BU;
          "HU":    op = MEM_OP_HU;
          default: stop_with_failure({"Unknown width code in test ", name});
        endcase
        name_q.push_back(name);
        is_read_q.push_back(dir == "R");
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(expected);
      end
    end
    $fclose(fd);
  endtask

  // Present one command and hold it until the LSU can take it
  task automatic issue_command(input int i);
    @(posedge clk);
    #2;
    cmd.addr  = addr_q[i];
    cmd.data  = data_q[i];
    cmd.read  = is_read_q[i];
    cmd.write = !is_read_q[i];
    cmd.op    = op_q[i];
    while (!lsu_ready) begin
      @(posedge clk);
      #2;
    end
    if (is_read_q[i]) begin
      pend_name.push_back(name_q[i]);
      pend_exp.push_back(exp_q[i]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    logic stall_now;
    bus_stall = 1'b0;
    forever begin
      @(posedge clk);
      stall_now = stall_en;
      #2;
      bus_stall = stall_now ? (($random(seed) & 3) == 0) : 1'b0;   // About one cycle in four
    end
  end

  initial begin
    logic [31:0] expected;
    string       test_name;
    forever begin
      @(negedge clk);
      if (!rst && mem_read_data_valid) begin
        assert (pend_exp.size() != 0)
          else stop_with_failure("Load result arrived with no load outstanding");
        expected  = pend_exp.pop_front();
        test_name = pend_name.pop_front();
        assert (mem_read_data === expected)
          else stop_with_failure($sformatf("FAILED %s expected %08h actual %08h",
                                           test_name, expected, mem_read_data));
      end
    end
  end

  initial begin
    wait (stim_ready);
    #(name_q.size() * 20 * 40);
    stop_with_failure($sformatf("Timeout with %0d load results never returned",
                                pend_exp.size()));
  end

  initial begin
    seed     = 32'hb326_68cb;
    rst      = 1'b1;
    cmd      = '0;
    stall_en = 1'b0;
    read_stim_file();
    stim_ready = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    repeat (4) begin
      @(negedge clk);
      assert (lsu_ready && !mem_read_data_valid)
        else stop_with_failure("LSU not idle after reset");
    end

    foreach (name_q[i]) begin
      if (name_q[i].substr(0, 2) == "bp_") begin
        stall_en = 1'b1;
      end
      issue_command(i);
    end
    @(posedge clk);
    #2;
    cmd = '0;

    while (pend_exp.size() != 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);   // Room for a stray extra result
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verilog/avl_sram_slave.sv */
`timescale 1ns/1ps

`include "core_lsu_params.svh"

module avl_sram_slave
  import core_lsu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,
  input  avl_req_t avl_req,
  output avl_rsp_t avl_rsp
);

  localparam int IDX_W = $clog2(`SRAM_WORDS);
  localparam int LAT   = `SRAM_RD_LAT;

  mem_word_u             mem [`SRAM_WORDS];
  mem_word_u             wr_word;
  logic [IDX_W-1:0]      idx;
  logic                  wr_accept;
  logic                  rd_accept;
  logic [LAT:0]          rd_valid;
  logic [LAT:0][31:0]    rd_data;

  assign idx       = avl_req.address[IDX_W+1:2];   // Wraps at SRAM_WORDS
  assign wr_word   = avl_req.write_data;
  assign wr_accept = avl_req.write && !stall;
  assign rd_accept = avl_req.read && !stall;

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int i = 0; i < 4; i++) begin
        if (avl_req.byte_en[i]) begin
          mem[idx].bytes[i] <= wr_word.bytes[i];
        end
      end
    end
  end

  // Stage 0 captures at acceptance, stage LAT drives the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= '0;
    end else begin
      rd_valid <= {rd_valid[LAT-1:0], rd_accept};
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= {rd_data[LAT-1:0], mem[idx].word};
  end

  assign avl_rsp.request_ready   = !stall;
  assign avl_rsp.read_data       = rd_data[LAT];
  assign avl_rsp.read_data_valid = rd_valid[LAT];

endmodule

/* verilog/core_lsu_params.svh */
`ifndef CORE_LSU_PARAMS_SVH
`define CORE_LSU_PARAMS_SVH

// Command FIFO entries in front of the address generator
`define CMD_FIFO_DEPTH 2

// SRAM size in 32-bit words
`define SRAM_WORDS 256

// Acceptance to read_data_valid
`define SRAM_RD_LAT 2

// Loads in flight tracked by the data generator
`define PEND_LD_DEPTH 4

`endif

/* verilog/core_lsu_pkg.sv */
package core_lsu_pkg;

  // funct3 width codes
  typedef enum logic [2:0] {
    MEM_OP_B  = 3'd0,
    MEM_OP_H  = 3'd1,
    MEM_OP_W  = 3'd2,
    MEM_OP_BU = 3'd4,
    MEM_OP_HU = 3'd5
  } mem_op_e;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;    // Store data, low aligned
    logic        read;
    logic        write;
    mem_op_e     op;
  } mem_cmd_t;

  typedef struct packed {
    logic [31:0] address;               // Word aligned
    logic        read;
    logic        write;
    logic [3:0]  byte_en;
    logic [31:0] write_data;
    logic        begin_burst_transfer;
    logic        burst_count;           // Single beat only
  } avl_req_t;

  typedef struct packed {
    logic        request_ready;
    logic [31:0] read_data;
    logic        read_data_valid;
  } avl_rsp_t;

  // One bus word, seen whole or by byte lane
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } mem_word_u;

endpackage

/* verilog/core_ma_lsu.sv */
`timescale 1ns/1ps

`include "core_lsu_params.svh"

module core_ma_lsu
  import core_lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mem_cmd_t    cmd,
  output logic        lsu_ready,
  output logic [31:0] mem_read_data,
  output logic        mem_read_data_valid,
  output avl_req_t    avl_req,
  input  avl_rsp_t    avl_rsp
);

  logic     fifo_write;
  logic     fifo_full;
  logic     fifo_empty;
  logic     head_pop;
  logic     head_valid;
  logic     load_issue;
  mem_cmd_t head;

  assign fifo_write = (cmd.read || cmd.write) && !fifo_full;
  assign lsu_ready  = !fifo_full;
  assign head_valid = !fifo_empty || fifo_write;   // Bypass shows the incoming command

  fifo_sync_bypass #(
    .DEPTH (`CMD_FIFO_DEPTH),
    .WIDTH ($bits(mem_cmd_t))
  ) i_cmd_fifo (
    .clk        (clk),
    .rst        (rst),
    .write      (fifo_write),
    .read       (head_pop),
    .write_data (cmd),
    .read_data  (head),
    .full       (fifo_full),
    .empty      (fifo_empty)
  );

  core_ma_lsu_generate_addr i_generate_addr (
    .clk           (clk),
    .rst           (rst),
    .head          (head),
    .head_valid    (head_valid),
    .pop           (head_pop),
    .avl_req       (avl_req),
    .request_ready (avl_rsp.request_ready)
  );

  // Loads are queued as they enter the request register
  assign load_issue = head_pop && head.read;

  core_ma_lsu_generate_data i_generate_data (
    .clk                 (clk),
    .rst                 (rst),
    .load_issue          (load_issue),
    .load_offset         (head.addr[1:0]),
    .load_op             (head.op),
    .avl_rsp             (avl_rsp),
    .mem_read_data       (mem_read_data),
    .mem_read_data_valid (mem_read_data_valid)
  );

endmodule

/* verilog/core_ma_lsu_generate_addr.sv */
`timescale 1ns/1ps

module core_ma_lsu_generate_addr
  import core_lsu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mem_cmd_t head,
  input  logic     head_valid,
  output logic     pop,
  output avl_req_t avl_req,
  input  logic     request_ready
);

  logic        req_read;
  logic        req_write;
  logic        req_valid;
  logic        load;
  logic [31:0] req_addr;
  logic [3:0]  req_be;
  logic [31:0] req_wdata;
  logic [3:0]  be_next;
  mem_word_u   wdata_next;

  assign req_valid = req_read | req_write;

  // Refill when idle or when the held request goes out this edge
  assign load = head_valid && (!req_valid || request_ready);
  assign pop  = load;

  always_comb begin
    be_next         = 4'b1111;
    wdata_next.word = head.data;
    case (head.op)
      MEM_OP_B, MEM_OP_BU: begin
        be_next          = 4'b0001 << head.addr[1:0];
        wdata_next.bytes = {4{head.data[7:0]}};   // Byte in every lane
      end
      MEM_OP_H, MEM_OP_HU: begin
        be_next         = 4'b0011 << head.addr[1:0];
        wdata_next.word = {2{head.data[15:0]}};
      end
      default: begin
        be_next         = 4'b1111;
        wdata_next.word = head.data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_read  <= 1'b0;
      req_write <= 1'b0;
    end else if (load) begin
      req_read  <= head.read;
      req_write <= head.write;
    end else if (request_ready) begin
      req_read  <= 1'b0;
      req_write <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      req_addr  <= {head.addr[31:2], 2'b00};
      req_be    <= be_next;
      req_wdata <= wdata_next.word;
    end
  end

  assign avl_req.address              = req_addr;
  assign avl_req.read                 = req_read;
  assign avl_req.write                = req_write;
  assign avl_req.byte_en              = req_be;
  assign avl_req.write_data           = req_wdata;
  assign avl_req.begin_burst_transfer = req_valid;
  assign avl_req.burst_count          = 1'b1;

endmodule

/* verilog/core_ma_lsu_generate_data.sv */
`timescale 1ns/1ps

`include "core_lsu_params.svh"

module core_ma_lsu_generate_data
  import core_lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        load_issue,
  input  logic [1:0]  load_offset,
  input  mem_op_e     load_op,
  input  avl_rsp_t    avl_rsp,
  output logic [31:0] mem_read_data,
  output logic        mem_read_data_valid
);

  logic [4:0]  pend_head;
  logic [1:0]  pend_offset;
  mem_op_e     pend_op;
  mem_word_u   rsp_word;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  logic [31:0] ext_data;

  // Offset and width of each load still waiting for its data
  fifo_sync_bypass #(
    .DEPTH (`PEND_LD_DEPTH),
    .WIDTH (5)
  ) i_pend_ld_fifo (
    .clk        (clk),
    .rst        (rst),
    .write      (load_issue),
    .read       (avl_rsp.read_data_valid),
    .write_data ({load_offset, load_op}),
    .read_data  (pend_head),
    .full       (),
    .empty      ()
  );

  assign pend_offset = pend_head[4:3];
  assign pend_op     = mem_op_e'(pend_head[2:0]);

  assign rsp_word.word = avl_rsp.read_data;
  assign sel_byte      = rsp_word.bytes[pend_offset];
  assign sel_half      = pend_offset[1] ? rsp_word.word[31:16] : rsp_word.word[15:0];

  always_comb begin
    case (pend_op)
      MEM_OP_B:  ext_data = {{24{sel_byte[7]}}, sel_byte};
      MEM_OP_BU: ext_data = {24'd0, sel_byte};
      MEM_OP_H:  ext_data = {{16{sel_half[15]}}, sel_half};
      MEM_OP_HU: ext_data = {16'd0, sel_half};
      default:   ext_data = rsp_word.word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_read_data_valid <= 1'b0;
    end else begin
      mem_read_data_valid <= avl_rsp.read_data_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (avl_rsp.read_data_valid) begin
      mem_read_data <= ext_data;
    end
  end

endmodule

/* verilog/core_ma_lsu_top.sv */
`timescale 1ns/1ps

module core_ma_lsu_top
  import core_lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mem_cmd_t    cmd,
  output logic        lsu_ready,
  input  logic        bus_stall,
  output logic [31:0] mem_read_data,
  output logic        mem_read_data_valid
);

  avl_req_t avl_req;
  avl_rsp_t avl_rsp;

  core_ma_lsu i_core_ma_lsu (
    .clk                 (clk),
    .rst                 (rst),
    .cmd                 (cmd),
    .lsu_ready           (lsu_ready),
    .mem_read_data       (mem_read_data),
    .mem_read_data_valid (mem_read_data_valid),
    .avl_req             (avl_req),
    .avl_rsp             (avl_rsp)
  );

  avl_sram_slave i_avl_sram_slave (
    .clk     (clk),
    .rst     (rst),
    .stall   (bus_stall),   // Back-pressure from outside
    .avl_req (avl_req),
    .avl_rsp (avl_rsp)
  );

endmodule

/* verilog/fifo_sync_bypass.sv */
`timescale 1ns/1ps

module fifo_sync_bypass #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             write,
  input  logic             read,
  input  logic [WIDTH-1:0] write_data,
  output logic [WIDTH-1:0] read_data,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             bypass;
  logic             do_write;
  logic             do_read;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign bypass    = empty && write && read;   // Consumed in flight, never stored
  assign do_write  = write && (!full || read) && !bypass;   // Same-cycle read frees a slot
  assign do_read   = read && !empty;
  assign read_data = empty ? write_data : mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= write_data;
    end
  end

endmodule
